// File: test/ob_cnt_stim.txt
// price goal nv attained, all decimal; entry i is priced 100 + 10*i
// entries 0 to nv-1 are valid, attained is the expected goal flag
1000 1023 16 1
250 1023 16 1
2000 0 16 1
50 1 16 0
100 1023 16 0
100 1 16 1
1000 1023 1 0
1000 1023 0 0
1000 3 3 1
155 6 16 1
205 1023 16 1
1000 11 12 1
1000 0 6 1
145 5 16 1
99 0 16 1
250 16 16 1
1000 1 15 1
160 7 16 1
65535 2 2 1
65535 1023 0 0

// File: all.f
+incdir+logic
logic/ob_cnt_pkg.sv
logic/cnt_ctrl_if.sv
logic/cnt_ctrl_fsm.sv
logic/round_sel.sv
logic/entry_filter_mux.sv
logic/csa_accum.sv
logic/ob_table_cnt.sv
test/tb_ob_table_cnt.sv

// File: Makefile
# Verilator flow for the order-book depth counter

TOP := tb_ob_table_cnt
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard logic/*.sv logic/*.svh test/*.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f all.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/10ps \
		-f all.f --top-module ob_table_cnt

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_ob_table_cnt.sv
/* Testbench for the depth counter that reads commands from the stimulus file,
   builds sorted ask tables and checks totals, goal flag, busy timing and hold */

`timescale 1ns/10ps
`default_nettype none

`include "ob_cnt_consts.svh"

module tb_ob_table_cnt;

  logic                                       clk = 1'b0;
  logic                                       rst_n;
  logic                                       cmd_vld;
  ob_cnt_pkg::price_t                         cmd_price;
  ob_cnt_pkg::quantity_t                      cmd_goal;
  logic [`OB_N_ENTRIES-1:0]                   tbl_vld;
  ob_cnt_pkg::price_t [`OB_N_ENTRIES-1:0]     tbl_price;
  ob_cnt_pkg::quantity_t [`OB_N_ENTRIES-1:0]  tbl_quantity;
  logic                                       busy;
  ob_cnt_pkg::acc_t                           rsp_quantity;
  logic                                       rsp_attained;

  // Stimulus columns with one entry per command
  int stim_price[$];
  int stim_goal[$];
  int stim_nv[$];
  int stim_flag[$];

  // Reference copy of the current table
  int model_price[`OB_N_ENTRIES];
  int model_qty[`OB_N_ENTRIES];

  logic [31:0] rng = 32'hb924;
  int errors = 0;
  int cycles = 0;
  int cycle_limit = 0;

  ob_table_cnt #(.is_ask(1'b1)) dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_vld      (cmd_vld),
    .cmd_price    (cmd_price),
    .cmd_goal     (cmd_goal),
    .tbl_vld      (tbl_vld),
    .tbl_price    (tbl_price),
    .tbl_quantity (tbl_quantity),
    .busy         (busy),
    .rsp_quantity (rsp_quantity),
    .rsp_attained (rsp_attained)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Qualifying quantity up to and including the first round with a gap
  function automatic int prefix_sum(int limit, int nv);
    int total;
    int idx;
    bit stop;
    bit qual;
    total = 0;
    stop  = 1'b0;
    for (int r = 0; r < `OB_ROUNDS; r++) begin
      if (!stop) begin
        for (int l = 0; l < `OB_LANES; l++) begin
          idx  = r * `OB_LANES + l;
          // Ask side trades at or below the limit
          qual = (idx < `OB_N_ENTRIES) && (idx < nv) && (model_price[idx] <= limit);
          if (qual) begin
            total += model_qty[idx];
          end else begin
            stop = 1'b1;
          end
        end
      end
    end
    return total;
  endfunction

  task automatic load_stimulus(output bit ok);
    int fd;
    int n;
    int p;
    int g;
    int v;
    int f;
    string line;
    ok = 1'b0;
    fd = $fopen("test/ob_cnt_stim.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // Comment and blank lines do not parse as four numbers
        if (n > 0 && $sscanf(line, "%d %d %d %d", p, g, v, f) == 4) begin
          stim_price.push_back(p);
          stim_goal.push_back(g);
          stim_nv.push_back(v);
          stim_flag.push_back(f);
        end
      end
      $fclose(fd);
      ok = (stim_price.size() > 0);
    end
  endtask

  // Sorted ascending prices with the first nv entries valid
  task automatic build_table(int nv);
    for (int i = 0; i < `OB_N_ENTRIES; i++) begin
      rng = xorshift32(rng);
      model_price[i] = 100 + 10 * i;
      // Quantity in 1..1022
      model_qty[i] = int'(rng % 32'd1022) + 1;
      tbl_vld[i]      <= (i < nv);
      tbl_price[i]    <= ob_cnt_pkg::price_t'(model_price[i]);
      tbl_quantity[i] <= ob_cnt_pkg::quantity_t'(model_qty[i]);
    end
  endtask

  task automatic expect_value(string name, int got, int exp);
    assert (got == exp) else begin
      $display("error t=%0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic run_command(int t);
    int price;
    int goal;
    int p_sum;
    int waited;
    int err0;
    int hold_q;
    int hold_a;
    price = stim_price[t];
    goal  = stim_goal[t];
    err0  = errors;

    @(posedge clk);
    build_table(stim_nv[t]);
    p_sum = prefix_sum(price, stim_nv[t]);
    cmd_price <= ob_cnt_pkg::price_t'(price);
    cmd_goal  <= ob_cnt_pkg::quantity_t'(goal);
    cmd_vld   <= 1'b1;

    // Accept edge
    @(posedge clk);
    cmd_vld <= 1'b0;
    @(negedge clk);
    expect_value("busy", int'(busy), 1);

    // Odd tests send a second command while busy and the DUT must drop it
    @(posedge clk);
    if (t % 2 == 1) begin
      cmd_price <= '0;
      cmd_goal  <= '0;
      cmd_vld   <= 1'b1;
    end
    @(posedge clk);
    cmd_vld <= 1'b0;

    // Edges since accept
    waited = 2;
    @(negedge clk);
    while (busy && waited < 6) begin
      @(negedge clk);
      waited++;
    end
    assert (!busy) else begin
      $display("busy still high %0d cycles after the command was accepted", waited);
      errors++;
    end

    if (p_sum < goal) begin
      expect_value("rsp_quantity", int'(rsp_quantity), p_sum);
      expect_value("rsp_attained", int'(rsp_attained), 0);
    end else begin
      expect_value("rsp_attained", int'(rsp_attained), 1);
      assert (int'(rsp_quantity) >= goal && int'(rsp_quantity) <= p_sum) else begin
        $display("error t=%0t rsp_quantity got %0d expected %0d..%0d",
                 $time, rsp_quantity, goal, p_sum);
        errors++;
      end
    end
    // Flag written in the stimulus line
    expect_value("rsp_attained", int'(rsp_attained), stim_flag[t]);

    // Responses hold while idle even as the command and table inputs move
    hold_q = int'(rsp_quantity);
    hold_a = int'(rsp_attained);
    @(posedge clk);
    cmd_price <= ~cmd_price;
    cmd_goal  <= '0;
    tbl_vld   <= ~tbl_vld;
    repeat (2) @(negedge clk);
    expect_value("busy", int'(busy), 0);
    expect_value("rsp_quantity", int'(rsp_quantity), hold_q);
    expect_value("rsp_attained", int'(rsp_attained), hold_a);

    $display("test %0d price=%0d goal=%0d nv=%0d quantity=%0d attained=%0d %s",
             t + 1, price, goal, stim_nv[t], hold_q, hold_a,
             (errors == err0) ? "ok" : "mismatch");
  endtask

  initial begin
    bit ok;
    rst_n        = 1'b0;
    cmd_vld      = 1'b0;
    cmd_price    = '0;
    cmd_goal     = '0;
    tbl_vld      = '0;
    tbl_price    = '0;
    tbl_quantity = '0;
    load_stimulus(ok);
    if (!ok) begin
      $display("stimulus file test/ob_cnt_stim.txt is missing or holds no commands");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      // Each command and its hold check fit in 10 cycles
      cycle_limit = 10 * stim_price.size() + 50;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      // Reset values
      @(negedge clk);
      expect_value("busy", int'(busy), 0);
      expect_value("rsp_quantity", int'(rsp_quantity), 0);
      expect_value("rsp_attained", int'(rsp_attained), 0);
      $display("test 0 reset values %s", (errors == 0) ? "ok" : "mismatch");

      for (int t = 0; t < stim_price.size(); t++) begin
        run_command(t);
      end

      $display("tests %0d, errors %0d", stim_price.size() + 1, errors);
      if (errors == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: logic/ob_table_cnt.sv
/* Depth counter top level: control interface, FSM, round selector,
   price filter and carry-save accumulator */

`timescale 1ns/10ps
`default_nettype none

`include "ob_cnt_consts.svh"

module ob_table_cnt #(
  parameter bit is_ask = 1'b1
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       cmd_vld,
  input  ob_cnt_pkg::price_t                         cmd_price,
  input  ob_cnt_pkg::quantity_t                      cmd_goal,
  input  logic [`OB_N_ENTRIES-1:0]                   tbl_vld,
  input  ob_cnt_pkg::price_t [`OB_N_ENTRIES-1:0]     tbl_price,
  input  ob_cnt_pkg::quantity_t [`OB_N_ENTRIES-1:0]  tbl_quantity,
  output logic                                       busy,
  output ob_cnt_pkg::acc_t                           rsp_quantity,
  output logic                                       rsp_attained
);

  cnt_ctrl_if ctrl ();

  // Current one-hot round
  ob_cnt_pkg::round_t round;

  // Slice register into the compressor
  ob_cnt_pkg::acc_t [`OB_LANES-1:0] slice;

  cnt_ctrl_fsm u_fsm (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_vld (cmd_vld),
    .ctrl    (ctrl.fsm),
    .busy    (busy)
  );

  round_sel u_round_sel (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl.sel),
    .round_sel (round)
  );

  entry_filter_mux #(.is_ask(is_ask)) u_filter (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_price    (cmd_price),
    .tbl_vld      (tbl_vld),
    .tbl_price    (tbl_price),
    .tbl_quantity (tbl_quantity),
    .round_sel    (round),
    .ctrl         (ctrl.filt),
    .slice        (slice)
  );

  csa_accum u_accum (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_goal     (cmd_goal),
    .slice        (slice),
    .ctrl         (ctrl.acc),
    .rsp_quantity (rsp_quantity)
  );

  // Goal flag straight from the accumulator
  assign rsp_attained = ctrl.attained;

endmodule

`default_nettype wire

// File: logic/csa_accum.sv
/* 8:2 carry-save compressor tree, sum and carry accumulator,
   goal register and final carry-propagate sum */

`timescale 1ns/10ps
`default_nettype none

`include "ob_cnt_consts.svh"

module csa_accum (
  input  logic                              clk,
  input  logic                              rst_n,
  input  ob_cnt_pkg::quantity_t             cmd_goal,
  input  ob_cnt_pkg::acc_t [`OB_LANES-1:0]  slice,
  cnt_ctrl_if.acc                           ctrl,
  output ob_cnt_pkg::acc_t                  rsp_quantity
);

  // Compressor operands, prior sum and carry first
  ob_cnt_pkg::acc_t [`OB_CSA_DEGREE-1:0] x;

  // Tree nodes, level by level
  ob_cnt_pkg::acc_t s0, c0, s1, c1, s2, c2, s3, c3, s4, c4;
  ob_cnt_pkg::acc_t csa_s, csa_c;

  ob_cnt_pkg::acc_t sum_q, carry_q, goal_q;
  logic [`OB_ACC_W:0] total_ext;

  // 3:2 full-adder row, returns {carry, sum}
  function automatic logic [2*`OB_ACC_W-1:0] csa3(ob_cnt_pkg::acc_t a,
                                                  ob_cnt_pkg::acc_t b,
                                                  ob_cnt_pkg::acc_t c);
    ob_cnt_pkg::acc_t s;
    ob_cnt_pkg::acc_t cy;
    s  = a ^ b ^ c;
    cy = ((a & b) | (a & c) | (b & c)) << 1;
    return {cy, s};
  endfunction

  assign x = {slice, carry_q, sum_q};

  // 8 -> 6 -> 4 -> 3 -> 2
  assign {c0, s0}       = csa3(x[0], x[1], x[2]);
  assign {c1, s1}       = csa3(x[3], x[4], x[5]);
  assign {c2, s2}       = csa3(s0, c0, s1);
  assign {c3, s3}       = csa3(c1, x[6], x[7]);
  assign {c4, s4}       = csa3(s2, c2, s3);
  assign {csa_c, csa_s} = csa3(s4, c4, c3);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q   <= '0;
      carry_q <= '0;
      // Out of reset no goal can be met
      goal_q  <= '1;
    end else if (ctrl.acc_init) begin
      sum_q   <= '0;
      carry_q <= '0;
      goal_q  <= ob_cnt_pkg::acc_t'(cmd_goal);
    end else if (ctrl.acc_upt) begin
      sum_q   <= csa_s;
      carry_q <= csa_c;
    end
  end

  // Carry-propagate to the reported total
  assign total_ext    = {1'b0, sum_q} + {1'b0, carry_q};
  assign rsp_quantity = total_ext[`OB_ACC_W-1:0];
  assign ctrl.attained = (rsp_quantity >= goal_q);

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    !total_ext[`OB_ACC_W]
  ) else $error("depth total overflowed the accumulator");

endmodule

`default_nettype wire

// File: logic/entry_filter_mux.sv
/* Price filter, per-lane round mux and slice register
   in front of the carry-save compressor */

`timescale 1ns/10ps
`default_nettype none

`include "ob_cnt_consts.svh"

module entry_filter_mux #(
  parameter bit is_ask = 1'b1
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  ob_cnt_pkg::price_t                            cmd_price,
  input  logic [`OB_N_ENTRIES-1:0]                      tbl_vld,
  input  ob_cnt_pkg::price_t [`OB_N_ENTRIES-1:0]        tbl_price,
  input  ob_cnt_pkg::quantity_t [`OB_N_ENTRIES-1:0]     tbl_quantity,
  input  ob_cnt_pkg::round_t                            round_sel,
  cnt_ctrl_if.filt                                      ctrl,
  output ob_cnt_pkg::acc_t [`OB_LANES-1:0]              slice
);

  // Limit held for the whole command
  ob_cnt_pkg::price_t limit_q;

  // Entry qualifies, by round and lane
  logic [`OB_ROUNDS-1:0][`OB_LANES-1:0] qual;

  // Qualified quantity or zero
  ob_cnt_pkg::acc_t [`OB_ROUNDS-1:0][`OB_LANES-1:0] lane_qty;

  // Selected round
  logic [`OB_LANES-1:0]             lane_vld;
  ob_cnt_pkg::acc_t [`OB_LANES-1:0] slice_d;

  // Ask side trades at or below the limit, bid side at or above
  function automatic logic price_ok(ob_cnt_pkg::price_t limit,
                                    ob_cnt_pkg::price_t entry);
    if (is_ask) begin
      return entry <= limit;
    end
    return entry >= limit;
  endfunction

  always_ff @(posedge clk) begin
    if (ctrl.sel_init) begin
      limit_q <= cmd_price;
    end
  end

  // Entry i sits in round i/6, lane i%6
  for (genvar r = 0; r < `OB_ROUNDS; r++) begin : g_round
    for (genvar l = 0; l < `OB_LANES; l++) begin : g_lane
      localparam int IDX = r * `OB_LANES + l;
      if (IDX < `OB_N_ENTRIES) begin : g_used
        assign qual[r][l]     = tbl_vld[IDX] && price_ok(limit_q, tbl_price[IDX]);
        assign lane_qty[r][l] = qual[r][l] ? ob_cnt_pkg::acc_t'(tbl_quantity[IDX]) : '0;
      end else begin : g_pad
        // Past the table end
        assign qual[r][l]     = 1'b0;
        assign lane_qty[r][l] = '0;
      end
    end
  end

  // AND-OR mux on the one-hot round
  always_comb begin
    for (int l = 0; l < `OB_LANES; l++) begin
      slice_d[l]  = '0;
      lane_vld[l] = 1'b0;
      for (int r = 0; r < `OB_ROUNDS; r++) begin
        slice_d[l]  = slice_d[l] | (lane_qty[r][l] & {`OB_ACC_W{round_sel[r]}});
        lane_vld[l] = lane_vld[l] | (qual[r][l] & round_sel[r]);
      end
    end
  end

  // Any gap means later rounds cannot qualify either
  assign ctrl.round_all_vld = &lane_vld;

  // Cleared on a new command so the first fold adds nothing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slice <= '0;
    end else if (ctrl.sel_init) begin
      slice <= '0;
    end else if (ctrl.slice_en) begin
      slice <= slice_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/round_sel.sv
/* One-hot round selector with last-round flag */

`timescale 1ns/10ps
`default_nettype none

`include "ob_cnt_consts.svh"

module round_sel (
  input  logic               clk,
  input  logic               rst_n,
  cnt_ctrl_if.sel            ctrl,
  output ob_cnt_pkg::round_t round_sel
);

  ob_cnt_pkg::round_t sel_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= ob_cnt_pkg::round_t'(1);
    end else if (ctrl.sel_init) begin
      // New command starts at round 0
      sel_q <= ob_cnt_pkg::round_t'(1);
    end else if (ctrl.sel_upt) begin
      // Rotate so the update in the final round stays one-hot
      sel_q <= {sel_q[`OB_ROUNDS-2:0], sel_q[`OB_ROUNDS-1]};
    end
  end

  assign round_sel = sel_q;

  // Top bit marks the final round
  assign ctrl.sel_last = sel_q[`OB_ROUNDS-1];

  a_sel_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot(sel_q)
  ) else $error("round select lost one-hot encoding");

endmodule

`default_nettype wire

// File: logic/cnt_ctrl_fsm.sv
/* Command FSM: accepts a command, runs the accumulate rounds,
   drains the last slice and raises busy while active */

`timescale 1ns/10ps
`default_nettype none

module cnt_ctrl_fsm (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           cmd_vld,
  cnt_ctrl_if.fsm        ctrl,
  output logic           busy
);

  ob_cnt_pkg::cnt_state_e state_q;
  ob_cnt_pkg::cnt_state_e state_d;

  // Search is over once any of these holds
  logic search_end;

  // Last round selected, goal met, or a hole in the sorted table
  assign search_end = ctrl.sel_last || ctrl.attained || !ctrl.round_all_vld;

  always_comb begin
    // Strobes default low, state holds
    state_d       = state_q;
    ctrl.acc_init = 1'b0;
    ctrl.acc_upt  = 1'b0;
    ctrl.sel_init = 1'b0;
    ctrl.sel_upt  = 1'b0;
    ctrl.slice_en = 1'b0;

    case (state_q)
      ob_cnt_pkg::IDLE: begin
        if (cmd_vld) begin
          // Clear the totals and point at round 0
          ctrl.acc_init = 1'b1;
          ctrl.sel_init = 1'b1;
          state_d       = ob_cnt_pkg::ACCUM;
        end
      end

      ob_cnt_pkg::ACCUM: begin
        // Register this round, fold the previous one
        ctrl.slice_en = 1'b1;
        ctrl.sel_upt  = 1'b1;
        ctrl.acc_upt  = 1'b1;
        if (search_end) begin
          state_d = ob_cnt_pkg::DRAIN;
        end
      end

      ob_cnt_pkg::DRAIN: begin
        // Slice register still holds the final round
        ctrl.acc_upt = 1'b1;
        state_d      = ob_cnt_pkg::DONE;
      end

      ob_cnt_pkg::DONE: begin
        // Totals settled, response valid from here on
        state_d = ob_cnt_pkg::IDLE;
      end

      default: begin
        state_d = ob_cnt_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ob_cnt_pkg::IDLE;
      busy    <= 1'b0;
    end else begin
      state_q <= state_d;
      // Registered copy of "not idle"
      busy    <= (state_d != ob_cnt_pkg::IDLE);
    end
  end

  // Busy only follows an accepted command
  a_busy_after_accept: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> $past(cmd_vld && (state_q == ob_cnt_pkg::IDLE))
  ) else $error("busy rose without an accepted command");

endmodule

`default_nettype wire

// File: logic/cnt_ctrl_if.sv
/* Control strobes and status between the command FSM and the datapath */

`timescale 1ns/10ps
`default_nettype none

interface cnt_ctrl_if;

  // Strobes from the FSM
  logic acc_init;
  logic acc_upt;
  logic sel_init;
  logic sel_upt;
  logic slice_en;

  // Status back to the FSM
  logic sel_last;
  logic round_all_vld;
  logic attained;

  modport fsm (
    output acc_init, acc_upt, sel_init, sel_upt, slice_en,
    input  sel_last, round_all_vld, attained
  );

  // Round counter
  modport sel (input sel_init, sel_upt, output sel_last);

  // Price filter and slice register
  modport filt (input sel_init, slice_en, output round_all_vld);

  // Carry-save accumulator
  modport acc (input acc_init, acc_upt, output attained);

endinterface

`default_nettype wire

// File: logic/ob_cnt_pkg.sv
/* Shared types of the depth counter: price, quantity, accumulator,
   one-hot round and FSM state */

`default_nettype none

`include "ob_cnt_consts.svh"

package ob_cnt_pkg;

  // Binary limit or table price
  typedef logic [`OB_PRICE_W-1:0] price_t;

  // Quantity of a single table entry
  typedef logic [`OB_QTY_W-1:0] quantity_t;

  // Running depth total
  typedef logic [`OB_ACC_W-1:0] acc_t;

  // One bit per round, exactly one set
  typedef logic [`OB_ROUNDS-1:0] round_t;

  // Command FSM states
  typedef enum logic [1:0] {
    IDLE,
    ACCUM,
    DRAIN,
    DONE
  } cnt_state_e;

endpackage

`default_nettype wire

// File: logic/ob_cnt_consts.svh
/* Sizing constants for the order-book depth counter:
   table size, compressor degree, lanes, rounds and field widths */

`ifndef OB_CNT_CONSTS_SVH
`define OB_CNT_CONSTS_SVH

// Price table depth
`define OB_N_ENTRIES 16

// Compressor inputs, two of them carry the prior sum and carry
`define OB_CSA_DEGREE 8

// Table entries folded per round
`define OB_LANES (`OB_CSA_DEGREE - 2)

// Rounds to cover the whole table, ceil(16 / 6)
`define OB_ROUNDS ((`OB_N_ENTRIES + `OB_LANES - 1) / `OB_LANES)

// Field widths; 16 x 1023 fits in 14 bits
`define OB_PRICE_W 16
`define OB_QTY_W 10
`define OB_ACC_W 14

`endif
